/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eth_tx
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
eth_pkg.sv
eth_crc32.sv
eth_tx_buffer.sv
eth_tx_mii.sv
eth_axil_regs.sv
eth_tx_top.sv
eth_tx_assertions.sv
tb_eth_tx.sv

/* eth_axil_regs.sv */
`timescale 1ns/1ps

module eth_axil_regs #(
   parameter int BUF_AW = 9
) (
   input  logic                TX_CLK,
   input  logic                tx_rst,
   input  eth_pkg::axil_req_t  req,
   output eth_pkg::axil_rsp_t  rsp,
   output eth_pkg::buf_wr_t    buf_wr,
   output logic                start,
   output logic [10:0]         nbytes,
   input  logic                ready,
   input  logic                done
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_ACK  = 2'd1;
   localparam logic [1:0] S_RESP = 2'd2;

   logic [1:0]           wstate;
   logic [1:0]           rstate;
   logic [15:0]          frames;
   logic [31:0]          rdata_q;
   logic                 wr_buf;
   logic                 wr_ctrl;
   eth_pkg::eth_wdata_u  wd;
   eth_pkg::eth_status_t status;

   assign wd = req.wdata;

   // the write lands in the cycle where awready and wready are high
   assign wr_buf  = (wstate == S_ACK) && (req.awaddr >= eth_pkg::BUF_BASE);
   assign wr_ctrl = (wstate == S_ACK) && (req.awaddr == eth_pkg::REG_CTRL);

   // go is dropped while a frame is still going out
   assign start  = wr_ctrl && wd.ctrl.go && ready;
   assign nbytes = wd.ctrl.len;

   always_comb begin
      buf_wr                   = '0;
      buf_wr.en                = wr_buf;
      buf_wr.addr[BUF_AW-1:0]  = req.awaddr[BUF_AW+1:2];
      buf_wr.data              = wd.lanes;
      buf_wr.strb              = req.wstrb;
   end

   always_comb begin
      status        = '0;
      status.ready  = ready;
      status.frames = frames;
   end

   // write channel
   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         wstate <= S_IDLE;
      end else begin
         case (wstate)
            S_IDLE: begin
               if (req.awvalid && req.wvalid) begin
                  wstate <= S_ACK;
               end
            end
            S_ACK: begin
               wstate <= S_RESP;
            end
            S_RESP: begin
               if (req.bready) begin
                  wstate <= S_IDLE;
               end
            end
            default: begin
               wstate <= S_IDLE;
            end
         endcase
      end
   end

   // read channel
   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         rstate <= S_IDLE;
      end else begin
         case (rstate)
            S_IDLE: begin
               if (req.arvalid) begin
                  rstate <= S_ACK;
               end
            end
            S_ACK: begin
               rstate <= S_RESP;
            end
            S_RESP: begin
               if (req.rready) begin
                  rstate <= S_IDLE;
               end
            end
            default: begin
               rstate <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge TX_CLK) begin
      if (rstate == S_ACK) begin
         rdata_q <= (req.araddr == eth_pkg::REG_STATUS) ? status : 32'h0;
      end
   end

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         frames <= '0;
      end else if (done) begin
         frames <= frames + 16'd1;
      end
   end

   always_comb begin
      rsp.awready = (wstate == S_ACK);
      rsp.wready  = (wstate == S_ACK);
      rsp.bvalid  = (wstate == S_RESP);
      rsp.bresp   = 2'b00;
      rsp.arready = (rstate == S_ACK);
      rsp.rvalid  = (rstate == S_RESP);
      rsp.rdata   = rdata_q;
      rsp.rresp   = 2'b00;
   end

endmodule

/* eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 (
   input  logic        TX_CLK,
   input  logic        tx_rst,
   input  logic        init,
   input  logic        en,
   input  logic [7:0]  data,
   output logic [31:0] fcs
);

   logic [31:0] crc_q;
   logic [31:0] crc_next;

   // reflected form, lsb of the byte enters first
   always_comb begin
      crc_next = crc_q ^ {24'h000000, data};
      for (int i = 0; i < 8; i++) begin
         if (crc_next[0]) begin
            crc_next = (crc_next >> 1) ^ eth_pkg::CRC_POLY;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         crc_q <= eth_pkg::CRC_INIT;
      end else if (init) begin
         crc_q <= eth_pkg::CRC_INIT;
      end else if (en) begin
         crc_q <= crc_next;
      end
   end

   // byte 0 of the fcs sits in bits 7:0, already in wire bit order
   assign fcs = ~crc_q;

endmodule

/* eth_pkg.sv */
package eth_pkg;

   // AXI4-Lite, manager to slave
   typedef struct packed {
      logic [11:0] awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        wvalid;
      logic        bready;
      logic [11:0] araddr;
      logic        arvalid;
      logic        rready;
   } axil_req_t;

   // AXI4-Lite, slave to manager
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic [19:0] rsvd;
      logic        go;
      logic [10:0] len;
   } eth_ctrl_t;

   // same write word, buffer bytes or control word by address
   typedef union packed {
      logic [3:0][7:0] lanes;
      eth_ctrl_t       ctrl;
   } eth_wdata_u;

   typedef struct packed {
      logic [14:0] rsvd;
      logic [15:0] frames;
      logic        ready;
   } eth_status_t;

   typedef struct packed {
      logic        en;
      logic [8:0]  addr;
      logic [31:0] data;
      logic [3:0]  strb;
   } buf_wr_t;

   typedef struct packed {
      logic       en;
      logic [3:0] data;
   } mii_tx_t;

   localparam logic [11:0] REG_CTRL   = 12'h000;
   localparam logic [11:0] REG_STATUS = 12'h004;
   localparam logic [11:0] BUF_BASE   = 12'h800;

   localparam int PREAMBLE_NIBBLES = 15;
   localparam int IFG_CYCLES       = 24;

   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

endpackage

/* eth_tx_assertions.sv */
`timescale 1ns/1ps

module eth_tx_assertions (
   input logic               TX_CLK,
   input logic               tx_rst,
   input logic               start,
   input logic [10:0]        nbytes,
   input logic               ready,
   input eth_pkg::mii_tx_t   mii,
   input eth_pkg::axil_req_t req,
   input eth_pkg::axil_rsp_t rsp
);

   int len_q;
   int run_len;

   // length of the frame in flight and its en-high cycles so far
   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         len_q   <= 0;
         run_len <= 0;
      end else if (start) begin
         len_q   <= int'(nbytes);
         run_len <= 0;
      end else if (mii.en) begin
         run_len <= run_len + 1;
      end
   end

   frame_len: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      $fell(mii.en) |-> (run_len == 2 * len_q + 24))
      else $error("mii en high for %0d cycles on a %0d byte frame", run_len, len_q);

   busy_in_frame: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      mii.en |-> !ready)
      else $error("ready high while mii en is high");

   bvalid_hold: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      (rsp.bvalid && !req.bready) |=> rsp.bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge TX_CLK) disable iff (tx_rst)
      (rsp.rvalid && !req.rready) |=> (rsp.rvalid && $stable(rsp.rdata)))
      else $error("rvalid or rdata changed before rready");

endmodule

bind eth_tx_top eth_tx_assertions u_chk (
   .TX_CLK (TX_CLK),
   .tx_rst (tx_rst),
   .start  (start),
   .nbytes (nbytes),
   .ready  (ready),
   .mii    (mii),
   .req    (axil_req),
   .rsp    (axil_rsp)
);

/* eth_tx_buffer.sv */
`timescale 1ns/1ps

module eth_tx_buffer #(
   parameter int BUF_AW = 9
) (
   input  logic              TX_CLK,
   input  eth_pkg::buf_wr_t  wr,
   input  logic [BUF_AW+1:0] rd_addr,
   output logic [7:0]        rd_data
);

   logic [3:0][7:0] mem [2**BUF_AW];
   logic [3:0][7:0] word_q;
   logic [1:0]      lane_q;

   // byte lane writes
   always_ff @(posedge TX_CLK) begin
      if (wr.en) begin
         for (int i = 0; i < 4; i++) begin
            if (wr.strb[i]) begin
               mem[wr.addr[BUF_AW-1:0]][i] <= wr.data[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge TX_CLK) begin
      word_q <= mem[rd_addr[BUF_AW+1:2]];
      lane_q <= rd_addr[1:0];
   end

   assign rd_data = word_q[lane_q];

endmodule

/* eth_tx_mii.sv */
`timescale 1ns/1ps

module eth_tx_mii #(
   parameter int BUF_AW = 9
) (
   input  logic              TX_CLK,
   input  logic              tx_rst,
   input  logic              start,
   input  logic [10:0]       nbytes,
   output logic [BUF_AW+1:0] rd_addr,
   input  logic [7:0]        rd_data,
   output logic              ready,
   output logic              done,
   output eth_pkg::mii_tx_t  mii
);

   localparam logic [2:0] ST_IDLE = 3'd0;
   localparam logic [2:0] ST_PRE  = 3'd1;
   localparam logic [2:0] ST_DATA = 3'd2;
   localparam logic [2:0] ST_FCS  = 3'd3;
   localparam logic [2:0] ST_GAP  = 3'd4;

   localparam logic [4:0] PRE_LAST = 5'(eth_pkg::PREAMBLE_NIBBLES);
   localparam logic [4:0] GAP_LAST = 5'(eth_pkg::IFG_CYCLES);

   logic [2:0]  state;
   logic [4:0]  cnt;
   logic [10:0] left;
   logic [7:0]  cur;
   logic        load_cur;
   logic        crc_init;
   logic        crc_en;
   logic [31:0] fcs;

   assign crc_init = start && (state == ST_IDLE);

   // byte goes into the crc as its high nibble is sent
   assign crc_en = (state == ST_DATA) && cnt[0];

   assign done = (state == ST_GAP) && (cnt == GAP_LAST);

   // take the next byte at end of preamble and after each high nibble
   assign load_cur = ((state == ST_PRE) && (cnt == PRE_LAST)) ||
                     ((state == ST_DATA) && cnt[0]);

   always_ff @(posedge TX_CLK) begin
      if (load_cur) begin
         cur <= rd_data;
      end
   end

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         state    <= ST_IDLE;
         cnt      <= '0;
         left     <= '0;
         rd_addr  <= '0;
         ready    <= 1'b1;
         mii.en   <= 1'b0;
         mii.data <= 4'h0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state   <= ST_PRE;
                  cnt     <= '0;
                  left    <= nbytes;
                  rd_addr <= '0;
                  ready   <= 1'b0;
               end
            end
            ST_PRE: begin
               mii.en   <= 1'b1;
               mii.data <= (cnt == PRE_LAST) ? 4'hD : 4'h5;
               cnt      <= cnt + 5'd1;
               if (cnt == PRE_LAST) begin
                  state   <= ST_DATA;
                  cnt     <= '0;
                  // byte 0 is in cur, start fetching byte 1
                  rd_addr <= rd_addr + 1'b1;
               end
            end
            ST_DATA: begin
               mii.data <= cnt[0] ? cur[7:4] : cur[3:0];
               cnt      <= cnt + 5'd1;
               if (cnt[0]) begin
                  rd_addr <= rd_addr + 1'b1;
                  left    <= left - 11'd1;
                  if (left == 11'd1) begin
                     state <= ST_FCS;
                     cnt   <= '0;
                  end
               end
            end
            ST_FCS: begin
               mii.data <= fcs[{cnt[2:0], 2'b00} +: 4];
               cnt      <= cnt + 5'd1;
               if (cnt[2:0] == 3'd7) begin
                  state <= ST_GAP;
                  cnt   <= '0;
               end
            end
            ST_GAP: begin
               mii.en   <= 1'b0;
               mii.data <= 4'h0;
               cnt      <= cnt + 5'd1;
               if (done) begin
                  state <= ST_IDLE;
                  ready <= 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   eth_crc32 u_crc (
      .TX_CLK (TX_CLK),
      .tx_rst (tx_rst),
      .init   (crc_init),
      .en     (crc_en),
      .data   (cur),
      .fcs    (fcs)
   );

endmodule

/* eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top #(
   parameter int BUF_AW = 9
) (
   input  logic               TX_CLK,
   input  logic               tx_rst,
   input  eth_pkg::axil_req_t axil_req,
   output eth_pkg::axil_rsp_t axil_rsp,
   output eth_pkg::mii_tx_t   mii
);

   eth_pkg::buf_wr_t  buf_wr;
   logic [BUF_AW+1:0] rd_addr;
   logic [7:0]        rd_data;
   logic              start;
   logic [10:0]       nbytes;
   logic              ready;
   logic              done;

   eth_axil_regs #(.BUF_AW(BUF_AW)) u_regs (
      .TX_CLK (TX_CLK),
      .tx_rst (tx_rst),
      .req    (axil_req),
      .rsp    (axil_rsp),
      .buf_wr (buf_wr),
      .start  (start),
      .nbytes (nbytes),
      .ready  (ready),
      .done   (done)
   );

   eth_tx_buffer #(.BUF_AW(BUF_AW)) u_buf (
      .TX_CLK  (TX_CLK),
      .wr      (buf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_tx_mii #(.BUF_AW(BUF_AW)) u_tx (
      .TX_CLK  (TX_CLK),
      .tx_rst  (tx_rst),
      .start   (start),
      .nbytes  (nbytes),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .ready   (ready),
      .done    (done),
      .mii     (mii)
   );

endmodule

/* tb_eth_tx.sv */
`timescale 1ns/1ps

module tb_eth_tx;

   typedef struct {
      string      name;
      int         len;
      int         seed_ofs;
      logic [3:0] strb;
      bit         mid_go;
      int         exp_frames;
   } frame_t;

   localparam int NUM_TESTS = 7;

   logic               TX_CLK;
   logic               tx_rst;
   eth_pkg::axil_req_t req;
   eth_pkg::axil_rsp_t rsp;
   eth_pkg::mii_tx_t   mii;

   frame_t      tbl [NUM_TESTS];
   logic [7:0]  exp_bytes [2048];
   logic [3:0]  cap [$];
   logic        en_prev = 1'b0;
   int          en_rises = 0;
   int          cycles = 0;
   int          limit = 1000000;
   int          errors = 0;
   int          passed = 0;
   int          failed = 0;
   int          frames_sent = 0;
   logic [31:0] lcg_state;
   string       cur_test = "reset";

   eth_tx_top #(.BUF_AW(9)) dut (
      .TX_CLK   (TX_CLK),
      .tx_rst   (tx_rst),
      .axil_req (req),
      .axil_rsp (rsp),
      .mii      (mii)
   );

   initial begin
      TX_CLK = 1'b0;
      forever #5 TX_CLK = ~TX_CLK;
   end

   // mii capture, one nibble per cycle while en is high
   always @(negedge TX_CLK) begin
      if (mii.en && !en_prev) begin
         en_rises++;
      end
      if (mii.en) begin
         cap.push_back(mii.data);
      end
      en_prev = mii.en;
   end

   always @(posedge TX_CLK) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] rand_byte();
      lcg_state = lcg_next(lcg_state);
      return lcg_state[23:16];
   endfunction

   // bitwise reflected crc-32 over the expected payload
   function automatic logic [31:0] crc_ref(input int n);
      logic [31:0] c;
      c = 32'hFFFFFFFF;
      for (int i = 0; i < n; i++) begin
         c = c ^ {24'h000000, exp_bytes[i]};
         for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   task automatic chk_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("ERR %s: expected %02h, got %02h", name, exp, act);
         errors++;
      end
   endtask

   task automatic chk_fcs(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERR %s fcs: expected %08h, got %08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic chk_status(input string name, input eth_pkg::eth_status_t exp,
                             input eth_pkg::eth_status_t act);
      if (act !== exp) begin
         $display("ERR %s status: expected ready %0b frames %0d, got ready %0b frames %0d",
                  name, exp.ready, exp.frames, act.ready, act.frames);
         errors++;
      end
   endtask

   task automatic chk_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) begin
         $display("ERR %s: expected %0h, got %0h", name, exp, act);
         errors++;
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold);
      @(negedge TX_CLK);
      req.awaddr  = addr;
      req.awvalid = 1'b1;
      req.wdata   = data;
      req.wstrb   = strb;
      req.wvalid  = 1'b1;
      @(negedge TX_CLK);
      while (!(rsp.awready && rsp.wready)) @(negedge TX_CLK);
      // handshake completes on the next rising edge
      @(negedge TX_CLK);
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      while (!rsp.bvalid) @(negedge TX_CLK);
      // keep bvalid waiting a little
      repeat (hold) @(negedge TX_CLK);
      chk_resp($sformatf("%s bresp", cur_test), 2'b00, rsp.bresp);
      req.bready = 1'b1;
      @(negedge TX_CLK);
      req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                            input int hold);
      @(negedge TX_CLK);
      req.araddr  = addr;
      req.arvalid = 1'b1;
      @(negedge TX_CLK);
      while (!rsp.arready) @(negedge TX_CLK);
      @(negedge TX_CLK);
      req.arvalid = 1'b0;
      while (!rsp.rvalid) @(negedge TX_CLK);
      // rvalid waits before rready
      repeat (hold) @(negedge TX_CLK);
      data = rsp.rdata;
      chk_resp($sformatf("%s rresp", cur_test), 2'b00, rsp.rresp);
      req.rready = 1'b1;
      @(negedge TX_CLK);
      req.rready = 1'b0;
   endtask

   task automatic report_test(input string name, input int err0);
      if (errors == err0) begin
         $display("test %s: ok", name);
         passed++;
      end else begin
         $display("test %s: %0d errors", name, errors - err0);
         failed++;
      end
   endtask

   task automatic check_reset();
      logic [31:0]          d;
      eth_pkg::eth_status_t st_exp;
      int                   err0;
      err0     = errors;
      cur_test = "reset";
      repeat (10) @(negedge TX_CLK);
      if (en_rises != 0 || mii.en !== 1'b0) begin
         $display("reset: mii en went high with no frame started");
         errors++;
      end
      axil_read(eth_pkg::REG_STATUS, d, 2);
      st_exp       = '0;
      st_exp.ready = 1'b1;
      chk_status("reset", st_exp, d);
      report_test("reset", err0);
   endtask

   task automatic run_frame(input int k);
      frame_t               t;
      int                   nwords;
      int                   n_exp;
      int                   rises0;
      int                   err0;
      int                   base;
      logic [31:0]          old_w;
      logic [31:0]          new_w;
      logic [31:0]          d;
      logic [31:0]          fcs_act;
      eth_pkg::eth_wdata_u  ctrl;
      eth_pkg::eth_status_t st;
      eth_pkg::eth_status_t st_exp;
      t         = tbl[k];
      err0      = errors;
      cur_test  = t.name;
      lcg_state = 32'd95903 + 32'(t.seed_ofs);
      nwords    = (t.len + 3) / 4;
      // full word first, then the strobed overwrite
      for (int w = 0; w < nwords; w++) begin
         for (int b = 0; b < 4; b++) begin
            old_w[8*b +: 8] = rand_byte();
         end
         for (int b = 0; b < 4; b++) begin
            new_w[8*b +: 8]    = rand_byte();
            exp_bytes[4*w + b] = t.strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
         end
         axil_write(eth_pkg::BUF_BASE + 12'(4 * w), old_w, 4'hF, 0);
         axil_write(eth_pkg::BUF_BASE + 12'(4 * w), new_w, t.strb,
                    int'(lcg_state[17:16]) % 3);
      end
      ctrl          = '0;
      ctrl.ctrl.go  = 1'b1;
      ctrl.ctrl.len = 11'(t.len);
      rises0        = en_rises;
      cap.delete();
      axil_write(eth_pkg::REG_CTRL, ctrl, 4'hF, 0);
      while (!mii.en) @(negedge TX_CLK);
      if (t.mid_go) begin
         repeat (t.len) @(negedge TX_CLK);
         axil_write(eth_pkg::REG_CTRL, ctrl, 4'hF, 1);
      end
      while (mii.en) @(negedge TX_CLK);
      do begin
         axil_read(eth_pkg::REG_STATUS, d, 0);
         st = d;
      end while (!st.ready);
      repeat (8) @(negedge TX_CLK);
      axil_read(eth_pkg::REG_STATUS, d, 1);
      st = d;
      frames_sent += t.exp_frames;
      if (en_rises - rises0 != t.exp_frames) begin
         $display("ERR %s frames: expected %0d, got %0d", t.name, t.exp_frames,
                  en_rises - rises0);
         errors++;
      end
      n_exp = 16 + 2 * t.len + 8;
      if (cap.size() != n_exp) begin
         $display("ERR %s nibbles: expected %0d, got %0d", t.name, n_exp, cap.size());
         errors++;
      end else begin
         for (int i = 0; i < 8; i++) begin
            chk_byte($sformatf("%s preamble %0d", t.name, i), (i == 7) ? 8'hD5 : 8'h55,
                     {cap[2*i + 1], cap[2*i]});
         end
         for (int i = 0; i < t.len; i++) begin
            chk_byte($sformatf("%s byte %0d", t.name, i), exp_bytes[i],
                     {cap[16 + 2*i + 1], cap[16 + 2*i]});
         end
         base = 16 + 2 * t.len;
         for (int i = 0; i < 4; i++) begin
            fcs_act[8*i +: 8] = {cap[base + 2*i + 1], cap[base + 2*i]};
         end
         chk_fcs(t.name, crc_ref(t.len), fcs_act);
      end
      st_exp        = '0;
      st_exp.ready  = 1'b1;
      st_exp.frames = 16'(frames_sent);
      chk_status(t.name, st_exp, st);
      report_test(t.name, err0);
   endtask

   initial begin
      req    = '0;
      tx_rst = 1'b1;
      tbl[0] = '{"len1",       1,  0, 4'hF, 1'b0, 1};
      tbl[1] = '{"len7",       7, 11, 4'hF, 1'b0, 1};
      tbl[2] = '{"len64",     64, 23, 4'hF, 1'b0, 1};
      tbl[3] = '{"strb5",     13, 37, 4'h5, 1'b0, 1};
      tbl[4] = '{"strbc",     22, 41, 4'hC, 1'b0, 1};
      tbl[5] = '{"midgo",     30, 53, 4'hF, 1'b1, 1};
      tbl[6] = '{"strb9_go",  45, 67, 4'h9, 1'b1, 1};
      limit = 300;
      for (int k = 0; k < NUM_TESTS; k++) begin
         limit += 2 * tbl[k].len + 24 + eth_pkg::IFG_CYCLES
                + 6 * 2 * ((tbl[k].len + 3) / 4) + 80;
      end
      repeat (4) @(posedge TX_CLK);
      @(negedge TX_CLK);
      tx_rst = 1'b0;
      check_reset();
      for (int k = 0; k < NUM_TESTS; k++) begin
         run_frame(k);
      end
      $display("tests passed %0d, failed %0d", passed, failed);
      if (failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
